//--- design/selftest_cfg.svh
// Self-test configuration macros: bus widths, test length, read latency, LFSR seed
`ifndef SELFTEST_CFG_SVH
`define SELFTEST_CFG_SVH

// ==================================================
// SRAM geometry
// ==================================================

// Address and word width of the board SRAM
`define SELFTEST_ADDR_W 8
`define SELFTEST_DATA_W 36

// Last address covered by the test, so N = STOP + 1 words
`define SELFTEST_STOP_ADDR 15

// Cycles from read request to data on the SRAM read bus
`define SELFTEST_RD_LATENCY 2

// ==================================================
// Pattern and result
// ==================================================

// Must be nonzero or the LFSR locks up
`define SELFTEST_LFSR_SEED 36'h5_A5C3_1E97

// Saturating mismatch counter width
`define SELFTEST_ERR_W 8

`endif

//--- design/mem_bus_pkg.sv
// SRAM word types, raw/fixed-pattern union and the LFSR step function
`default_nettype none

`include "selftest_cfg.svh"

package mem_bus_pkg;

   typedef logic [`SELFTEST_ADDR_W-1:0] sram_addr_t;
   typedef logic [`SELFTEST_DATA_W-1:0] sram_data_t;

   // Marker nibble at the top of every fixed-pattern word
   localparam logic [3:0] FIXED_MARKER = 4'hA;

   // Fixed pattern layout, a word that names its own address
   typedef struct packed {
      logic [3:0]  marker;
      logic [15:0] addr_echo;
      logic [15:0] addr_inv;
   } fixed_word_t;

   // Same 36 bits seen raw or as the fixed pattern
   typedef union packed {
      sram_data_t  raw;
      fixed_word_t fixed;
   } sram_word_u;

   // Taps for x^36 + x^25 + 1, right-shifting Galois form
   localparam sram_data_t LFSR_TAPS = 36'h8_0100_0000;

   // One LFSR step
   function automatic sram_data_t lfsr_next(input sram_data_t state);
      sram_data_t nxt;
      nxt = state >> 1;
      if (state[0]) begin
         nxt = nxt ^ LFSR_TAPS;
      end
      return nxt;
   endfunction

endpackage

`default_nettype wire

//--- design/selftest_pkg.sv
// Test mode, generator phase and result counter types
`default_nettype none

`include "selftest_cfg.svh"

package selftest_pkg;

   // ==================================================
   // Control types
   // ==================================================

   // Pattern source chosen at start
   typedef enum logic {
      FIXED  = 1'b0,
      RANDOM = 1'b1
   } test_mode_e;

   // Generator FSM states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      WRITE = 2'd1,
      READ  = 2'd2,
      DRAIN = 2'd3
   } gen_phase_e;

   // ==================================================
   // Result types
   // ==================================================

   typedef logic [`SELFTEST_ERR_W-1:0] err_count_t;

   // Counter stops here instead of wrapping
   localparam err_count_t ERR_MAX = '1;

endpackage

`default_nettype wire

//--- design/sram_req_if.sv
// Request stream and aligned compare stream interfaces
`default_nettype none

// One SRAM request per cycle while valid, never stalled
interface sram_req_if;
   logic                   valid;
   logic                   we;
   mem_bus_pkg::sram_addr_t addr;
   // Write data, or the expected word on a read
   mem_bus_pkg::sram_data_t data;

   modport src (output valid, output we, output addr, output data);
   modport dst (input valid, input we, input addr, input data);
endinterface

// Read data lined up with its expected word
interface chk_if;
   logic                   valid;
   mem_bus_pkg::sram_addr_t addr;
   mem_bus_pkg::sram_data_t expected;
   mem_bus_pkg::sram_data_t actual;

   modport src (output valid, output addr, output expected, output actual);
   modport dst (input valid, input addr, input expected, input actual);
endinterface

`default_nettype wire

//--- design/pattern_gen.sv
// Pattern producer with write/read/drain phase FSM
`default_nettype none

`include "selftest_cfg.svh"

module pattern_gen (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  selftest_pkg::test_mode_e mode,
   output logic                     busy,
   output logic                     last,
   sram_req_if.src                  req
);

   localparam int DRAIN_W = $clog2(`SELFTEST_RD_LATENCY + 1);
   localparam mem_bus_pkg::sram_data_t SEED = `SELFTEST_LFSR_SEED;

   selftest_pkg::gen_phase_e phase;
   selftest_pkg::test_mode_e mode_q;
   logic [DRAIN_W-1:0]       drain_cnt;
   mem_bus_pkg::sram_data_t  lfsr;
   mem_bus_pkg::sram_data_t  lfsr_step;
   mem_bus_pkg::sram_addr_t  addr_inc;
   logic                     take;
   logic                     at_stop;
   logic                     drain_end;

   // Build one pattern word for the given address
   function automatic mem_bus_pkg::sram_data_t make_word(
      input selftest_pkg::test_mode_e m,
      input mem_bus_pkg::sram_addr_t  a,
      input mem_bus_pkg::sram_data_t  rnd
   );
      mem_bus_pkg::sram_word_u w;
      if (m == selftest_pkg::FIXED) begin
         w.fixed.marker    = mem_bus_pkg::FIXED_MARKER;
         w.fixed.addr_echo = 16'(a);
         w.fixed.addr_inv  = ~16'(a);
      end else begin
         w.raw = rnd;
      end
      return w.raw;
   endfunction

   assign take      = start && (phase == selftest_pkg::IDLE);
   assign at_stop   = (req.addr == mem_bus_pkg::sram_addr_t'(`SELFTEST_STOP_ADDR));
   assign drain_end = (drain_cnt == DRAIN_W'(`SELFTEST_RD_LATENCY - 1));
   assign lfsr_step = mem_bus_pkg::lfsr_next(lfsr);
   assign addr_inc  = req.addr + 1'b1;

   assign busy = (phase != selftest_pkg::IDLE);
   // Last drain cycle lines up with the final compare
   assign last = (phase == selftest_pkg::DRAIN) && drain_end;

   // ==================================================
   // Phase FSM
   // ==================================================
   always_ff @(posedge clk) begin
      if (rst) begin
         phase     <= selftest_pkg::IDLE;
         req.valid <= 1'b0;
         req.we    <= 1'b0;
         drain_cnt <= '0;
      end else begin
         case (phase)
            selftest_pkg::IDLE: begin
               if (take) begin
                  phase     <= selftest_pkg::WRITE;
                  req.valid <= 1'b1;
                  req.we    <= 1'b1;
               end
            end
            selftest_pkg::WRITE: begin
               if (at_stop) begin
                  phase  <= selftest_pkg::READ;
                  req.we <= 1'b0;
               end
            end
            selftest_pkg::READ: begin
               if (at_stop) begin
                  phase     <= selftest_pkg::DRAIN;
                  req.valid <= 1'b0;
                  drain_cnt <= '0;
               end
            end
            default: begin
               // Wait out reads still in flight
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_end) begin
                  phase <= selftest_pkg::IDLE;
               end
            end
         endcase
      end
   end

   // Address, LFSR and word, restarted at each phase
   always_ff @(posedge clk) begin
      if (take) begin
         mode_q   <= mode;
         req.addr <= '0;
         lfsr     <= SEED;
         req.data <= make_word(mode, '0, SEED);
      end else if (phase == selftest_pkg::WRITE || phase == selftest_pkg::READ) begin
         if (at_stop) begin
            req.addr <= '0;
            lfsr     <= SEED;
            req.data <= make_word(mode_q, '0, SEED);
         end else begin
            req.addr <= addr_inc;
            lfsr     <= lfsr_step;
            req.data <= make_word(mode_q, addr_inc, lfsr_step);
         end
      end
   end

   a_no_req_in_idle: assert property (
      @(posedge clk) disable iff (rst)
      (phase == selftest_pkg::IDLE) |-> !req.valid
   );

endmodule

`default_nettype wire

//--- design/read_pipe.sv
// Read alignment pipe that delays read tags by the SRAM latency
`default_nettype none

`include "selftest_cfg.svh"

module read_pipe (
   input  logic                    clk,
   input  logic                    rst,
   sram_req_if.dst                 req,
   input  mem_bus_pkg::sram_data_t rdata,
   chk_if.src                      chk
);

   localparam int LAT = `SELFTEST_RD_LATENCY;

   logic                    vld_q  [LAT];
   mem_bus_pkg::sram_addr_t addr_q [LAT];
   mem_bus_pkg::sram_data_t exp_q  [LAT];
   logic                    rd_in;
   logic                    in_flight;

   // Only reads are tracked
   assign rd_in = req.valid && !req.we;

   // Any read still travelling down the pipe
   always_comb begin
      in_flight = 1'b0;
      for (int i = 0; i < LAT; i++) begin
         in_flight = in_flight | vld_q[i];
      end
   end

   // ==================================================
   // Tag shift pipeline
   // ==================================================
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < LAT; i++) begin
            vld_q[i] <= 1'b0;
         end
      end else begin
         vld_q[0] <= rd_in;
         for (int i = 1; i < LAT; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      addr_q[0] <= req.addr;
      exp_q[0]  <= req.data;
      for (int i = 1; i < LAT; i++) begin
         addr_q[i] <= addr_q[i-1];
         exp_q[i]  <= exp_q[i-1];
      end
   end

   // Tail entry meets the SRAM data of the same read
   assign chk.valid    = vld_q[LAT-1];
   assign chk.addr     = addr_q[LAT-1];
   assign chk.expected = exp_q[LAT-1];
   assign chk.actual   = rdata;

   // Writes only arrive once every read has left the pipe
   a_no_write_in_flight: assert property (
      @(posedge clk) disable iff (rst)
      (req.valid && req.we) |-> !in_flight
   );

endmodule

`default_nettype wire

//--- design/result_checker.sv
// Result checker: word compare, saturating error count, done and fail
`default_nettype none

module result_checker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  logic                     last,
   chk_if.dst                       chk,
   output logic                     done,
   output logic                     fail,
   output selftest_pkg::err_count_t err_count,
   output mem_bus_pkg::sram_addr_t  first_err_addr
);

   mem_bus_pkg::sram_word_u exp_w;
   mem_bus_pkg::sram_word_u act_w;
   logic                    running;
   logic                    clear;
   logic                    mismatch;

   // Start while a test runs is dropped, as in the generator
   assign clear = start && !running;

   assign exp_w.raw = chk.expected;
   assign act_w.raw = chk.actual;
   assign mismatch  = chk.valid && (exp_w.raw != act_w.raw);

   // ==================================================
   // Run and done flags
   // ==================================================
   always_ff @(posedge clk) begin
      if (rst) begin
         running <= 1'b0;
         done    <= 1'b0;
      end else if (clear) begin
         running <= 1'b1;
         done    <= 1'b0;
      end else if (last) begin
         running <= 1'b0;
         done    <= 1'b1;
      end
   end

   // Mismatch counter, holds at its maximum
   always_ff @(posedge clk) begin
      if (rst) begin
         err_count <= '0;
      end else if (clear) begin
         err_count <= '0;
      end else if (mismatch && err_count != selftest_pkg::ERR_MAX) begin
         err_count <= err_count + 1'b1;
      end
   end

   // First bad address, captured while the count is still zero
   always_ff @(posedge clk) begin
      if (clear) begin
         first_err_addr <= '0;
      end else if (mismatch && err_count == '0) begin
         first_err_addr <= chk.addr;
      end
   end

   assign fail = (err_count != '0);

   a_err_monotonic: assert property (
      @(posedge clk) disable iff (rst)
      !clear |=> (err_count >= $past(err_count))
   );

endmodule

`default_nettype wire

//--- design/mem_selftest_top.sv
// SRAM self-test top level: generator, read pipe and checker on plain pins
`default_nettype none

module mem_selftest_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  selftest_pkg::test_mode_e mode,
   output mem_bus_pkg::sram_addr_t  sram_addr,
   output logic                     sram_we,
   output logic                     sram_en,
   output mem_bus_pkg::sram_data_t  sram_wdata,
   input  mem_bus_pkg::sram_data_t  sram_rdata,
   output logic                     busy,
   output logic                     done,
   output logic                     fail,
   output selftest_pkg::err_count_t err_count,
   output mem_bus_pkg::sram_addr_t  first_err_addr
);

   sram_req_if req_bus ();
   chk_if      chk_bus ();

   logic drain_last;

   pattern_gen u_gen (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .mode  (mode),
      .busy  (busy),
      .last  (drain_last),
      .req   (req_bus.src)
   );

   read_pipe u_pipe (
      .clk   (clk),
      .rst   (rst),
      .req   (req_bus.dst),
      .rdata (sram_rdata),
      .chk   (chk_bus.src)
   );

   result_checker u_chk (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .last           (drain_last),
      .chk            (chk_bus.dst),
      .done           (done),
      .fail           (fail),
      .err_count      (err_count),
      .first_err_addr (first_err_addr)
   );

   // SRAM pins, expected data stays off the write bus
   assign sram_en    = req_bus.valid;
   assign sram_we    = req_bus.valid && req_bus.we;
   assign sram_addr  = req_bus.addr;
   assign sram_wdata = req_bus.we ? req_bus.data : '0;

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Free-running testbench clock source
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD = 40
) (
   output logic clk
);

   // Low first, so the first rising edge comes half a period in
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2);
         clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_top.sv
// Testbench top with SRAM model, read faults, reference model, test sequence, checks and timeout
`default_nettype none

`include "selftest_cfg.svh"

module tb_top;

   localparam int N         = `SELFTEST_STOP_ADDR + 1;
   localparam int DEPTH     = 1 << `SELFTEST_ADDR_W;
   localparam int DONE_CYC  = 2 * N + 3;
   localparam int NUM_TESTS = 8;
   localparam int TIMEOUT   = NUM_TESTS * (DONE_CYC + 20);
   localparam int ERR_SAT   = (1 << `SELFTEST_ERR_W) - 1;

   logic                       clk;
   logic                       rst;
   logic                       start;
   selftest_pkg::test_mode_e   mode;
   mem_bus_pkg::sram_addr_t    sram_addr;
   logic                       sram_we;
   logic                       sram_en;
   mem_bus_pkg::sram_data_t    sram_wdata;
   mem_bus_pkg::sram_data_t    sram_rdata = '0;
   logic                       busy;
   logic                       done;
   logic                       fail;
   selftest_pkg::err_count_t   err_count;
   mem_bus_pkg::sram_addr_t    first_err_addr;

   // SRAM contents, expected words and fault table
   mem_bus_pkg::sram_data_t    mem        [DEPTH];
   mem_bus_pkg::sram_data_t    exp_word   [DEPTH];
   mem_bus_pkg::sram_data_t    fault_mask [DEPTH];
   logic                       fault      [DEPTH];
   mem_bus_pkg::sram_data_t    rd_stage = '0;

   int tests = 0;
   int checks = 0;
   int errors = 0;
   int cycle_cnt = 0;

   tb_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

   mem_selftest_top dut (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .mode           (mode),
      .sram_addr      (sram_addr),
      .sram_we        (sram_we),
      .sram_en        (sram_en),
      .sram_wdata     (sram_wdata),
      .sram_rdata     (sram_rdata),
      .busy           (busy),
      .done           (done),
      .fail           (fail),
      .err_count      (err_count),
      .first_err_addr (first_err_addr)
   );

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at time %0t: %s got %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   // ==================================================
   // SRAM model with two-cycle read latency
   // ==================================================
   always @(posedge clk) begin
      if (sram_en && sram_we) begin
         mem[sram_addr] <= sram_wdata;
         check_value("sram_wdata", 64'(sram_wdata), 64'(exp_word[sram_addr]));
      end
      if (sram_en && !sram_we) begin
         // Faulted addresses return a corrupted word
         rd_stage <= fault[sram_addr] ? (mem[sram_addr] ^ fault_mask[sram_addr])
                                      : mem[sram_addr];
      end
      sram_rdata <= rd_stage;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // ==================================================
   // Reference model
   // ==================================================
   task automatic build_expected(input selftest_pkg::test_mode_e m);
      mem_bus_pkg::sram_data_t lfsr;
      lfsr = `SELFTEST_LFSR_SEED;
      for (int a = 0; a < DEPTH; a++) begin
         if (m == selftest_pkg::FIXED) begin
            exp_word[a] = {4'hA, 16'(a), ~16'(a)};
         end else begin
            exp_word[a] = lfsr;
         end
         lfsr = mem_bus_pkg::lfsr_next(lfsr);
      end
   endtask

   // Pick distinct fault addresses inside the tested range
   task automatic set_faults(input int count);
      int placed;
      int a;
      for (int i = 0; i < DEPTH; i++) begin
         fault[i] = 1'b0;
      end
      placed = 0;
      while (placed < count) begin
         a = $urandom % N;
         if (!fault[a]) begin
            fault[a] = 1'b1;
            fault_mask[a] = mem_bus_pkg::sram_data_t'({$urandom, $urandom});
            if (fault_mask[a] == '0) begin
               fault_mask[a] = 1;
            end
            placed++;
         end
      end
   endtask

   function automatic int lowest_fault();
      for (int a = 0; a < N; a++) begin
         if (fault[a]) begin
            return a;
         end
      end
      return 0;
   endfunction

   task automatic report_test(input string name, input int base);
      tests++;
      if (errors == base) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d error(s)", name, errors - base);
      end
   endtask

   // ==================================================
   // Test sequences
   // ==================================================
   task automatic run_test(input string name, input selftest_pkg::test_mode_e m,
                           input int n_faults, input bit poke_busy);
      int base;
      int cycles;
      int exp_cnt;
      bit poke;
      base = errors;
      build_expected(m);
      set_faults(n_faults);
      exp_cnt = (n_faults > ERR_SAT) ? ERR_SAT : n_faults;
      @(posedge clk);
      #1;
      mode = m;
      start = 1'b1;
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
         // Strobes in the write phase and on the last compare must change nothing
         poke = poke_busy && (cycles == 6 || cycles == 2 * N + 2);
         start = poke;
         if (poke) begin
            mode = (m == selftest_pkg::FIXED) ? selftest_pkg::RANDOM : selftest_pkg::FIXED;
         end
      end while (!done && cycles < DONE_CYC + 20);
      if (!done) begin
         errors++;
         $display("Test %s: done did not rise within %0d cycles of start", name, cycles);
      end else begin
         check_value("done latency", 64'(cycles), 64'(DONE_CYC));
      end
      check_value("busy", 64'(busy), 64'(0));
      check_value("fail", 64'(fail), 64'(n_faults != 0));
      check_value("err_count", 64'(err_count), 64'(exp_cnt));
      if (n_faults != 0) begin
         check_value("first_err_addr", 64'(first_err_addr), 64'(lowest_fault()));
      end
      report_test(name, base);
   endtask

   task automatic reset_mid_test();
      int base;
      base = errors;
      build_expected(selftest_pkg::FIXED);
      set_faults(0);
      @(posedge clk);
      #1;
      mode = selftest_pkg::FIXED;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      // Somewhere in the read phase
      repeat (N + 3) @(posedge clk);
      #1;
      check_value("busy", 64'(busy), 64'(1));
      rst = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      check_value("busy", 64'(busy), 64'(0));
      check_value("done", 64'(done), 64'(0));
      check_value("fail", 64'(fail), 64'(0));
      check_value("sram_we", 64'(sram_we), 64'(0));
      check_value("sram_en", 64'(sram_en), 64'(0));
      check_value("err_count", 64'(err_count), 64'(0));
      report_test("mid_reset", base);
   endtask

   initial begin
      void'($urandom(40904));
      rst = 1'b1;
      start = 1'b0;
      mode = selftest_pkg::FIXED;
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] <= mem_bus_pkg::sram_data_t'(i * 40503) ^ 36'h3_C0FF_EE00;
         exp_word[i] = '0;
         fault[i] = 1'b0;
         fault_mask[i] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      run_test("fixed_clean", selftest_pkg::FIXED, 0, 1'b0);
      run_test("random_clean", selftest_pkg::RANDOM, 0, 1'b0);
      run_test("fixed_one_fault", selftest_pkg::FIXED, 1, 1'b0);
      run_test("random_one_fault", selftest_pkg::RANDOM, 1, 1'b0);
      run_test("multi_fault",
               (($urandom % 2) != 0) ? selftest_pkg::RANDOM : selftest_pkg::FIXED,
               2 + int'($urandom % 4), 1'b0);
      run_test("busy_start", selftest_pkg::RANDOM, 1, 1'b1);
      reset_mid_test();
      run_test("after_reset", selftest_pkg::RANDOM, 0, 1'b0);

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/mem_bus_pkg.sv
design/selftest_pkg.sv
design/sram_req_if.sv
design/pattern_gen.sv
design/read_pipe.sv
design/result_checker.sv
design/mem_selftest_top.sv
verification/tb_clock_gen.sv
verification/tb_top.sv

//--- Makefile
# Verilator build, run, lint and clean for the SRAM self-test project

VERILATOR ?= verilator
TOP       ?= tb_top
LINT_TOP  ?= mem_selftest_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Output is shown live; the status comes from the search for the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILE_LIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
